// ==== hdl/neural_config.svh ====
`ifndef NEURAL_CONFIG_SVH
`define NEURAL_CONFIG_SVH

// bfloat16 word layout
`define NC_DATA_W 16
`define NC_EXP_W 8
`define NC_MAN_W 7

// Systolic array side
`define NC_N 2

// Serial line, clk cycles per bit
`define NC_CLKS_PER_BIT 16

// Frame delimiters
`define NC_SOF 8'hFE
`define NC_EOF 8'hFF

`endif

// ==== hdl/neural_pkg.sv ====
`default_nettype none

`include "neural_config.svh"

package neural_pkg;

    typedef struct packed {
        logic                 sign;
        logic [`NC_EXP_W-1:0] exp;
        logic [`NC_MAN_W-1:0] man;
    } bf16_fields_t;

    // Raw bits for magnitude compare, fields for arithmetic
    typedef union packed {
        logic [`NC_DATA_W-1:0] bits;
        bf16_fields_t          f;
    } bf16_u;

    typedef logic [3:0] store_addr_t;

    localparam store_addr_t STORE_A_BASE = 4'd0;  // A, row-major
    localparam store_addr_t STORE_B_BASE = 4'd4;  // B, row-major
    localparam store_addr_t STORE_C_BASE = 4'd8;  // Result C

    typedef enum logic [2:0] {
        CS_SOF,    // Hunting for start byte
        CS_DATA,   // Operand bytes
        CS_EOF,    // End byte check
        CS_RUN,    // Core is computing
        CS_FETCH,  // Reading a C word
        CS_LATCH,  // C word arrives
        CS_SEND    // Reply bytes
    } codec_state_t;

endpackage

`default_nettype wire

// ==== hdl/word_store_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "neural_config.svh"

interface word_store_if import neural_pkg::*; ();

    logic                  req;
    logic                  we;
    store_addr_t           addr;
    logic [`NC_DATA_W-1:0] wdata;
    logic                  gnt;    // Same cycle as req when granted
    logic [`NC_DATA_W-1:0] rdata;  // Valid the cycle after a read grant

    modport peer (output req, we, addr, wdata, input gnt, rdata);
    modport store (input req, we, addr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

// ==== hdl/word_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "neural_config.svh"

module word_store import neural_pkg::*; (
    input wire logic    clk,
    input wire logic    reset,
    word_store_if.store codec,
    word_store_if.store core
);

    store_addr_t           addr;
    logic                  wr_en;
    logic [`NC_DATA_W-1:0] wdata;
    logic [`NC_DATA_W-1:0] rdata_q;
    logic [`NC_DATA_W-1:0] mem [12];

    // Fixed priority, codec first
    assign codec.gnt = codec.req;
    assign core.gnt  = core.req && !codec.req;

    always_comb begin
        if (codec.req) begin
            addr  = codec.addr;
            wr_en = codec.we;
            wdata = codec.wdata;
        end else begin
            addr  = core.addr;
            wr_en = core.req && core.we;
            wdata = core.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= mem[addr];
        end
    end

    // Only the granted peer looks at it
    assign codec.rdata = rdata_q;
    assign core.rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/uart_link.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "neural_config.svh"

module uart_link (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       rxd_i,
    output logic            txd_o,
    output logic            rx_valid_o,
    output logic [7:0]      rx_byte_o,
    input  wire logic       tx_start_i,
    input  wire logic [7:0] tx_byte_i,
    output logic            tx_busy_o
);

    localparam int CW = $clog2(`NC_CLKS_PER_BIT);
    localparam logic [CW-1:0] FULL_BIT = CW'(`NC_CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF_BIT = CW'(`NC_CLKS_PER_BIT / 2 - 1);

    logic [1:0]    rxd_sync;
    logic          rx_active;
    logic [CW-1:0] rx_cnt;
    logic [3:0]    rx_bit;    // 0 start, 1 to 8 data, 9 stop
    logic [7:0]    rx_shift;
    logic [CW-1:0] tx_cnt;
    logic [3:0]    tx_bit;
    logic [9:0]    tx_shift;  // Stop, data, start

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rxd_sync   <= 2'b11;
            rx_active  <= 1'b0;
            rx_cnt     <= '0;
            rx_bit     <= '0;
            rx_shift   <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rxd_sync   <= {rxd_sync[0], rxd_i};
            rx_valid_o <= 1'b0;
            if (!rx_active) begin
                if (!rxd_sync[1]) begin   // Falling start edge
                    rx_active <= 1'b1;
                    rx_cnt    <= HALF_BIT;
                    rx_bit    <= '0;
                end
            end else if (rx_cnt != '0) begin
                rx_cnt <= rx_cnt - 1'b1;
            end else begin
                // Mid-bit sample point
                rx_cnt <= FULL_BIT;
                rx_bit <= rx_bit + 1'b1;
                if (rx_bit == 4'd0) begin
                    if (rxd_sync[1]) begin
                        rx_active <= 1'b0;   // Glitch, not a start bit
                    end
                end else if (rx_bit == 4'd9) begin
                    rx_active  <= 1'b0;
                    rx_valid_o <= rxd_sync[1];  // Framing error drops the byte
                end else begin
                    rx_shift <= {rxd_sync[1], rx_shift[7:1]};  // LSB first
                end
            end
        end
    end

    assign rx_byte_o = rx_shift;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tx_busy_o <= 1'b0;
            tx_cnt    <= '0;
            tx_bit    <= '0;
            tx_shift  <= '1;
        end else if (!tx_busy_o) begin
            if (tx_start_i) begin
                tx_busy_o <= 1'b1;
                tx_cnt    <= FULL_BIT;
                tx_bit    <= '0;
                tx_shift  <= {1'b1, tx_byte_i, 1'b0};
            end
        end else if (tx_cnt != '0) begin
            tx_cnt <= tx_cnt - 1'b1;
        end else begin
            tx_cnt   <= FULL_BIT;
            tx_bit   <= tx_bit + 1'b1;
            tx_shift <= {1'b1, tx_shift[9:1]};
            if (tx_bit == 4'd9) begin
                tx_busy_o <= 1'b0;   // End of stop bit
            end
        end
    end

    assign txd_o = tx_busy_o ? tx_shift[0] : 1'b1;

endmodule

`default_nettype wire

// ==== hdl/frame_codec.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "neural_config.svh"

module frame_codec import neural_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       rx_valid_i,
    input  wire logic [7:0] rx_byte_i,
    output logic            tx_start_o,
    output logic [7:0]      tx_byte_o,
    input  wire logic       tx_busy_i,
    output logic            run_o,
    input  wire logic       done_i,
    word_store_if.peer      store
);

    codec_state_t          state;
    logic [3:0]            byte_idx;    // Operand byte or reply byte
    logic                  wr_pend;
    logic [`NC_DATA_W-1:0] word_q;
    store_addr_t           addr_q;
    logic                  tx_ready;
    logic                  fetch_next;
    logic [7:0]            reply_byte;

    assign tx_ready   = !tx_busy_i && !tx_start_o;
    assign fetch_next = !byte_idx[0] && !byte_idx[3];  // After bytes 0, 2, 4 and 6

    always_comb begin
        if (byte_idx == 4'd0) begin
            reply_byte = `NC_SOF;
        end else if (byte_idx == 4'd9) begin
            reply_byte = `NC_EOF;
        end else if (byte_idx[0]) begin
            reply_byte = word_q[15:8];   // High byte first
        end else begin
            reply_byte = word_q[7:0];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state      <= CS_SOF;
            byte_idx   <= '0;
            wr_pend    <= 1'b0;
            run_o      <= 1'b0;
            tx_start_o <= 1'b0;
        end else begin
            run_o      <= 1'b0;
            tx_start_o <= 1'b0;
            if (store.gnt) begin
                wr_pend <= 1'b0;
            end
            case (state)
                CS_SOF: begin
                    if (rx_valid_i && rx_byte_i == `NC_SOF) begin
                        state    <= CS_DATA;
                        byte_idx <= '0;
                    end
                end
                CS_DATA: begin
                    if (rx_valid_i) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx[0]) begin
                            wr_pend <= 1'b1;   // Word complete
                        end
                        if (byte_idx == 4'd15) begin
                            state <= CS_EOF;
                        end
                    end
                end
                CS_EOF: begin
                    if (rx_valid_i) begin
                        if (rx_byte_i == `NC_EOF) begin
                            run_o <= 1'b1;
                            state <= CS_RUN;
                        end else begin
                            state <= CS_SOF;   // Bad frame, no reply
                        end
                    end
                end
                CS_RUN: begin
                    if (done_i) begin
                        state    <= CS_SEND;
                        byte_idx <= '0;
                    end
                end
                CS_SEND: begin
                    if (tx_ready) begin
                        tx_start_o <= 1'b1;
                        byte_idx   <= byte_idx + 1'b1;
                        if (byte_idx == 4'd9) begin
                            state <= CS_SOF;
                        end else if (fetch_next) begin
                            state <= CS_FETCH;
                        end
                    end
                end
                CS_FETCH: begin
                    if (store.gnt) begin
                        state <= CS_LATCH;
                    end
                end
                CS_LATCH: state <= CS_SEND;
                default:  state <= CS_SOF;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CS_DATA && rx_valid_i) begin
            if (byte_idx[0]) begin
                word_q[7:0] <= rx_byte_i;
                addr_q      <= byte_idx[3] ? STORE_B_BASE + store_addr_t'(byte_idx[2:1])
                                           : STORE_A_BASE + store_addr_t'(byte_idx[2:1]);
            end else begin
                word_q[15:8] <= rx_byte_i;
            end
        end
        if (state == CS_SEND && tx_ready) begin
            tx_byte_o <= reply_byte;
            if (fetch_next) begin
                addr_q <= STORE_C_BASE + store_addr_t'(byte_idx[2:1]);
            end
        end
        if (state == CS_LATCH) begin
            word_q <= store.rdata;
        end
    end

    assign store.req   = wr_pend || state == CS_FETCH;
    assign store.we    = wr_pend;
    assign store.addr  = addr_q;
    assign store.wdata = word_q;

endmodule

`default_nettype wire

// ==== hdl/bf16_pe.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "neural_config.svh"

module bf16_pe import neural_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  weight_load_i,
    input  wire bf16_u weight_i,
    input  wire logic  step_i,
    input  wire bf16_u act_i,
    input  wire bf16_u psum_i,
    output bf16_u      act_o,
    output bf16_u      psum_o
);

    localparam int E = `NC_EXP_W;
    localparam int M = `NC_MAN_W;
    localparam logic [E+1:0] BIAS = (E+2)'(2 ** (E - 1) - 1);

    bf16_u          weight;
    bf16_u          prod;
    bf16_u          big;
    bf16_u          little;
    bf16_u          sum;
    logic [2*M+1:0] man_prod;
    logic [E+1:0]   exp_sum;
    logic [E-1:0]   exp_diff;
    logic [M:0]     sig_small;
    logic [M+1:0]   sig_sum;

    // Truncating multiply with hidden bits restored
    always_comb begin
        man_prod = {1'b1, act_i.f.man} * {1'b1, weight.f.man};
        exp_sum  = {2'b00, act_i.f.exp} + {2'b00, weight.f.exp} + (E+2)'(man_prod[2*M+1]);
        prod.f.sign = act_i.f.sign ^ weight.f.sign;
        prod.f.exp  = E'(exp_sum - BIAS);
        prod.f.man  = man_prod[2*M+1] ? man_prod[2*M:M+1] : man_prod[2*M-1:M];
        if (act_i.f.exp == '0 || weight.f.exp == '0) begin
            prod.bits = '0;
        end else if (exp_sum <= BIAS || exp_sum - BIAS >= (E+2)'(2 ** E - 1)) begin
            prod.f.exp = '1;    // Out of range
            prod.f.man = '0;
        end
    end

    // Truncating add with the larger magnitude first
    always_comb begin
        if (psum_i.bits[`NC_DATA_W-2:0] < prod.bits[`NC_DATA_W-2:0]) begin
            big    = prod;
            little = psum_i;
        end else begin
            big    = psum_i;
            little = prod;
        end
        exp_diff  = big.f.exp - little.f.exp;
        sig_small = {1'b1, little.f.man} >> exp_diff;
        sig_sum   = {2'b01, big.f.man} + {1'b0, sig_small};
        sum.f.sign = big.f.sign;
        sum.f.exp  = big.f.exp + E'(sig_sum[M+1]);   // Carry renormalizes
        sum.f.man  = sig_sum[M+1] ? sig_sum[M:1] : sig_sum[M-1:0];
        if (&big.f.exp || &little.f.exp) begin
            sum.bits = '0;
        end else if (little.f.exp == '0) begin
            sum = big;          // Zero operand
        end else if (big.f.sign != little.f.sign) begin
            sum.bits = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (weight_load_i) begin
            weight <= weight_i;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            act_o  <= '0;
            psum_o <= '0;
        end else if (step_i) begin
            act_o  <= act_i;   // East
            psum_o <= sum;     // South
        end
    end

endmodule

`default_nettype wire

// ==== hdl/systolic_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "neural_config.svh"

module systolic_core import neural_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  run_i,
    output logic       done_o,
    word_store_if.peer store
);

    localparam int N      = `NC_N;
    localparam int SR_LEN = 2 * N - 1;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_READ  = 2'd1;
    localparam logic [1:0] ST_STEP  = 2'd2;
    localparam logic [1:0] ST_WRITE = 2'd3;

    logic [1:0]            state;
    logic [3:0]            rd_cnt;     // A words then B words
    logic                  cap_vld;
    logic [2:0]            cap_idx;
    logic [2:0]            step_cnt;
    logic [1:0]            wr_idx;
    logic                  step;
    logic [N*N-1:0]        wload;
    logic [`NC_DATA_W-1:0] act_sr [N][SR_LEN];
    logic [`NC_DATA_W-1:0] c_q [N*N];
    bf16_u                 pe_act [N][N+1];
    bf16_u                 pe_psum [N+1][N];

    assign step = state == ST_STEP;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= ST_IDLE;
            rd_cnt   <= '0;
            cap_vld  <= 1'b0;
            cap_idx  <= '0;
            step_cnt <= '0;
            wr_idx   <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o  <= 1'b0;
            cap_vld <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (run_i) begin
                        state  <= ST_READ;
                        rd_cnt <= '0;
                    end
                end
                ST_READ: begin
                    if (store.gnt) begin
                        rd_cnt  <= rd_cnt + 1'b1;
                        cap_vld <= 1'b1;
                        cap_idx <= rd_cnt[2:0];
                    end
                    if (cap_vld && cap_idx == 3'(2 * N * N - 1)) begin
                        state    <= ST_STEP;
                        step_cnt <= '0;
                    end
                end
                ST_STEP: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == 3'(2 * N)) begin   // 2N+1 steps
                        state  <= ST_WRITE;
                        wr_idx <= '0;
                    end
                end
                default: begin
                    if (store.gnt) begin
                        wr_idx <= wr_idx + 1'b1;
                        if (wr_idx == 2'(N * N - 1)) begin
                            state  <= ST_IDLE;
                            done_o <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Skewed activation rows, row k starts k steps late
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && run_i) begin
            for (int k = 0; k < N; k++) begin
                for (int p = 0; p < SR_LEN; p++) begin
                    act_sr[k][p] <= '0;
                end
            end
        end else if (step) begin
            for (int k = 0; k < N; k++) begin
                for (int p = 0; p < SR_LEN - 1; p++) begin
                    act_sr[k][p] <= act_sr[k][p+1];
                end
                act_sr[k][SR_LEN-1] <= '0;
            end
        end else if (cap_vld) begin
            for (int k = 0; k < N; k++) begin
                for (int i = 0; i < N; i++) begin
                    if (cap_idx == 3'(N * i + k)) begin
                        act_sr[k][i+k] <= store.rdata;   // A(i,k)
                    end
                end
            end
        end
        // C(i,j) leaves the bottom row after step i+j+N-1
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                if (step && step_cnt == 3'(i + j + N)) begin
                    c_q[N*i+j] <= pe_psum[N][j];
                end
            end
        end
    end

    for (genvar k = 0; k < N; k++) begin : g_row
        assign pe_act[k][0] = act_sr[k][0];
        for (genvar j = 0; j < N; j++) begin : g_col
            assign wload[N*k+j] = cap_vld && cap_idx == 3'(N * N + N * k + j);  // B(k,j)
            bf16_pe i_bf16_pe (
                .clk           (clk),
                .reset         (reset),
                .weight_load_i (wload[N*k+j]),
                .weight_i      (store.rdata),
                .step_i        (step),
                .act_i         (pe_act[k][j]),
                .psum_i        (pe_psum[k][j]),
                .act_o         (pe_act[k][j+1]),
                .psum_o        (pe_psum[k+1][j])
            );
        end
    end

    for (genvar j = 0; j < N; j++) begin : g_top
        assign pe_psum[0][j] = '0;
    end

    assign store.req   = (state == ST_READ && !rd_cnt[3]) || state == ST_WRITE;
    assign store.we    = state == ST_WRITE;
    assign store.addr  = (state == ST_WRITE) ? STORE_C_BASE + store_addr_t'(wr_idx) :
                         rd_cnt[2] ? STORE_B_BASE + store_addr_t'(rd_cnt[1:0]) :
                                     STORE_A_BASE + store_addr_t'(rd_cnt[1:0]);
    assign store.wdata = c_q[wr_idx];

endmodule

`default_nettype wire

// ==== hdl/neural_chip.sv ====
`timescale 1ns/1ns
`default_nettype none

module neural_chip (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic rxd_i,
    output logic      txd_o,
    output logic      mult_done_o
);

    logic       rx_valid;
    logic [7:0] rx_byte;
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;
    logic       run;
    logic       done;

    word_store_if codec_port ();
    word_store_if core_port ();

    uart_link i_uart_link (
        .clk        (clk),
        .reset      (reset),
        .rxd_i      (rxd_i),
        .txd_o      (txd_o),
        .rx_valid_o (rx_valid),
        .rx_byte_o  (rx_byte),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .tx_busy_o  (tx_busy)
    );

    frame_codec i_frame_codec (
        .clk        (clk),
        .reset      (reset),
        .rx_valid_i (rx_valid),
        .rx_byte_i  (rx_byte),
        .tx_start_o (tx_start),
        .tx_byte_o  (tx_byte),
        .tx_busy_i  (tx_busy),
        .run_o      (run),
        .done_i     (done),
        .store      (codec_port.peer)
    );

    systolic_core i_systolic_core (
        .clk    (clk),
        .reset  (reset),
        .run_i  (run),
        .done_o (done),
        .store  (core_port.peer)
    );

    word_store i_word_store (
        .clk   (clk),
        .reset (reset),
        .codec (codec_port.store),
        .core  (core_port.store)
    );

    assign mult_done_o = done;

endmodule

`default_nettype wire

// ==== tests/tb_neural_chip.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "neural_config.svh"

module tb_neural_chip import neural_pkg::*; ();

    localparam int BIT_CLKS      = `NC_CLKS_PER_BIT;
    localparam int FIRST_TIMEOUT = 20 * 40 * BIT_CLKS;  // Whole frame with gaps, then compute
    localparam int NEXT_TIMEOUT  = 4 * BIT_CLKS;
    localparam int QUIET_BITS    = 40;

    logic        clk;
    logic        reset;
    logic        rxd;
    logic        txd;
    logic        mult_done;
    logic [31:0] rng_state;
    bf16_u       ops [8];      // A then B, row-major
    bf16_u       exp_c [4];
    int          done_cnt;
    int          start_pulses;  // done_cnt at the last detected start bit
    int          value_errors;
    int          timeout_errors;
    int          other_errors;

    neural_chip i_neural_chip (
        .clk         (clk),
        .reset       (reset),
        .rxd_i       (rxd),
        .txd_o       (txd),
        .mult_done_o (mult_done)
    );

    always #2 clk = ~clk;

    always @(negedge clk) begin
        if (mult_done === 1'b1) begin
            done_cnt <= done_cnt + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_byte(input logic [8*16-1:0] name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail %0s: expected byte %h, got %h", name, expected, actual);
        end
    endtask

    task automatic check_word(input logic [8*16-1:0] name, input bf16_u expected,
                              input bf16_u actual);
        if (actual.bits !== expected.bits) begin
            value_errors++;
            $display("Fail %0s: expected word %h, got %h", name, expected.bits, actual.bits);
        end
    endtask

    task automatic check_pulse(input logic [8*16-1:0] name, input int expected,
                               input int actual);
        if (actual != expected) begin
            value_errors++;
            $display("Fail %0s: expected %0d mult_done_o pulses, got %0d",
                     name, expected, actual);
        end
    endtask

    task automatic idle_bits(input int n);
        repeat (n * BIT_CLKS) @(posedge clk);
    endtask

    // 8N1, LSB first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rxd <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    task automatic send_gapped(input logic [7:0] data);
        rng_state = xorshift32(rng_state);
        idle_bits(int'(rng_state % 21));  // 0 to 20 idle bit times
        send_byte(data);
    endtask

    task automatic send_frame(input logic [7:0] end_byte);
        send_gapped(`NC_SOF);
        for (int w = 0; w < 8; w++) begin
            send_gapped(ops[w].bits[15:8]);   // High byte first
            send_gapped(ops[w].bits[7:0]);
        end
        send_gapped(end_byte);
    endtask

    task automatic recv_byte(input int timeout, output logic [7:0] data, output logic ok);
        int waited;
        ok     = 1'b0;
        data   = '0;
        waited = 0;
        @(negedge clk);
        while (txd !== 1'b0 && waited < timeout) begin
            @(negedge clk);
            waited++;
        end
        if (txd === 1'b0) begin
            start_pulses = done_cnt;
            repeat (BIT_CLKS / 2) @(negedge clk);   // Mid start bit
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge clk);
                data[i] = txd;
            end
            repeat (BIT_CLKS) @(negedge clk);
            if (txd !== 1'b1) begin
                other_errors++;
                $display("Stop bit of reply byte %h was low", data);
            end
            ok = 1'b1;
        end
    endtask

    task automatic receive_reply(input logic [8*16-1:0] name, input int base);
        logic [7:0] data;
        logic [7:0] hi;
        logic [7:0] lo;
        logic       ok;
        bf16_u      word;
        recv_byte(FIRST_TIMEOUT, data, ok);
        if (ok) begin
            check_pulse(name, 1, start_pulses - base);  // Done comes before the reply
            check_byte(name, `NC_SOF, data);
        end
        for (int w = 0; w < 4 && ok; w++) begin
            recv_byte(NEXT_TIMEOUT, hi, ok);
            if (ok) begin
                recv_byte(NEXT_TIMEOUT, lo, ok);
            end
            word.bits = {hi, lo};
            if (ok) begin
                check_word(name, exp_c[w], word);
            end
        end
        if (ok) begin
            recv_byte(NEXT_TIMEOUT, data, ok);
        end
        if (ok) begin
            check_byte(name, `NC_EOF, data);
            check_pulse(name, 1, done_cnt - base);
        end else begin
            timeout_errors++;
            $display("Timeout waiting for a reply byte in case %0s", name);
        end
    endtask

    // A rejected frame must leave the line idle
    task automatic watch_silence(input logic [8*16-1:0] name, input int base);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < QUIET_BITS * BIT_CLKS) begin
            @(negedge clk);
            waited++;
            seen = (txd === 1'b0);
        end
        if (seen) begin
            other_errors++;
            $display("Case %0s got a reply although its end byte was wrong", name);
        end
        check_pulse(name, 0, done_cnt - base);
    endtask

    initial begin
        int               fd;
        int               count;
        int               n_cases;
        int               bad_end;
        int               base;
        logic             idle_ok;
        logic [7:0]       junk;
        logic [15:0]      w [12];
        logic [8*200-1:0] line;
        logic [8*16-1:0]  name;

        clk            = 1'b0;
        reset          = 1'b0;
        rxd            = 1'b1;
        rng_state      = 32'd48642;
        done_cnt       = 0;
        start_pulses   = 0;
        value_errors   = 0;
        timeout_errors = 0;
        other_errors   = 0;
        n_cases        = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b1;

        idle_ok = 1'b1;
        for (int i = 0; i < 100 && idle_ok; i++) begin
            @(negedge clk);
            if (txd !== 1'b1 || mult_done !== 1'b0) begin
                idle_ok = 1'b0;
                value_errors++;
                $display("Fail idle: expected txd_o 1 and mult_done_o 0, got %b and %b",
                         txd, mult_done);
            end
        end

        fd = $fopen("tests/neural_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open tests/neural_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                count = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h",
                                name, bad_end, w[0], w[1], w[2], w[3], w[4], w[5],
                                w[6], w[7], w[8], w[9], w[10], w[11]);
                if (count == 14) begin     // Comment lines fall through
                    n_cases++;
                    for (int i = 0; i < 8; i++) begin
                        ops[i].bits = w[i];
                    end
                    for (int i = 0; i < 4; i++) begin
                        exp_c[i].bits = w[8+i];
                    end
                    if (n_cases % 2 == 0) begin
                        for (int g = 0; g < 2; g++) begin
                            rng_state = xorshift32(rng_state);
                            junk      = rng_state[7:0];
                            send_byte(junk == `NC_SOF ? 8'h5A : junk);  // Line noise
                        end
                    end
                    base = done_cnt;
                    if (bad_end != 0) begin
                        send_frame(8'h55);
                        watch_silence(name, base);
                    end else begin
                        fork
                            send_frame(`NC_EOF);
                            receive_reply(name, base);
                        join
                    end
                end
            end
            $fclose(fd);
        end
        if (n_cases == 0) begin
            other_errors++;
            $display("No cases were read from tests/neural_cases.txt");
        end

        $display("Errors: %0d wrong values, %0d timeouts, %0d other in %0d cases",
                 value_errors, timeout_errors, other_errors, n_cases);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/neural_pkg.sv
hdl/word_store_if.sv
hdl/word_store.sv
hdl/uart_link.sv
hdl/frame_codec.sv
hdl/bf16_pe.sv
hdl/systolic_core.sv
hdl/neural_chip.sv
tests/tb_neural_chip.sv

// ==== Bender.yml ====
package:
  name: neural_chip

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/neural_pkg.sv
      - hdl/word_store_if.sv
      - hdl/word_store.sv
      - hdl/uart_link.sv
      - hdl/frame_codec.sv
      - hdl/bf16_pe.sv
      - hdl/systolic_core.sv
      - hdl/neural_chip.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_neural_chip.sv

// ==== tests/neural_cases.txt ====
# name bad_end A00 A01 A10 A11 B00 B01 B10 B11 C00 C01 C10 C11
# Words are bfloat16 hex, bad_end 1 sends a wrong end byte and expects no reply
identity      0 3F80 4000 4040 4080 3F80 0000 0000 3F80 3F80 4000 4040 4080
integers      0 3F80 4000 4040 4080 40A0 40C0 40E0 4100 4198 41B0 422C 4248
fractions     0 3F00 3FC0 3E80 4000 4000 4080 3F80 3F00 4020 4030 4020 4000
bad_end       1 3F80 4000 4040 4080 40A0 40C0 40E0 4100 0000 0000 0000 0000
after_bad     0 4000 0000 0000 4000 4040 3F80 3F80 4040 40C0 4000 4000 40C0
zero_overflow 0 3F80 BF80 7180 0000 4000 7180 4040 0000 0000 7180 7200 0000
underflow     0 0D80 3F80 3F80 3F80 0D80 3F80 4080 3F80 4080 3F80 4080 4000
truncate      0 3F81 3F80 3FFF 3F80 3F81 3FFF 3B80 3F80 3F82 4040 4000 409F
